// ==== rtl/layer_pkg.sv ====
package layer_pkg;

	localparam int RF_DEPTH  = 16;
	localparam int MEM_DEPTH = 64;
	localparam int INT_DEPTH = 4;

	// Upper nibble of a message address
	localparam logic [3:0] LAYER_PREFIX = 4'h5;
	localparam logic [3:0] REPLY_PREFIX = 4'h1;

	// Function ids in the lower nibble
	localparam logic [3:0] FU_SLEEP     = 4'd0;
	localparam logic [3:0] FU_RF_WRITE  = 4'd2;
	localparam logic [3:0] FU_RF_READ   = 4'd3;
	localparam logic [3:0] FU_MEM_WRITE = 4'd4;
	localparam logic [3:0] FU_MEM_READ  = 4'd5;

	typedef logic [7:0]                   addr_t;
	typedef logic [31:0]                  word_t;
	typedef logic [23:0]                  rf_data_t;
	typedef logic [3:0]                   rf_idx_t;
	typedef logic [5:0]                   mem_addr_t;
	typedef logic [INT_DEPTH-1:0]         int_vec_t;
	typedef logic [$clog2(INT_DEPTH)-1:0] int_idx_t;

	// Whole register file, index 0 in the low bits
	typedef rf_data_t [RF_DEPTH-1:0] rf_file_t;

	typedef struct packed {
		addr_t addr;
		word_t data;
	} lc_msg_t;

	typedef struct packed {
		addr_t dest;
		word_t payload;
	} int_action_t;

	typedef enum logic [2:0] {
		LC_IDLE,
		LC_MEM_DATA,
		LC_MEM_WAIT,
		LC_REPLY,
		LC_INT_LOAD,
		LC_INT_TX,
		LC_INT_CLR,
		LC_SLEEP
	} lc_state_t;

	typedef enum logic [2:0] {
		PWR_OFF,
		PWR_UP,
		PWR_CLK_ON,
		PWR_RST_OFF,
		PWR_ACTIVE,
		PWR_ISO_ON,
		PWR_RST_ON,
		PWR_CLK_OFF
	} pwr_state_t;

endpackage

// ==== rtl/int_action_rom.sv ====
`timescale 1ns/1ns

module int_action_rom
(
	input  layer_pkg::int_idx_t    int_sel,
	output layer_pkg::int_action_t int_action
);

	layer_pkg::int_action_t rom [layer_pkg::INT_DEPTH];

	// Line i goes to function 8+i of the reply prefix
	always_comb
	begin
		for (int i = 0; i < layer_pkg::INT_DEPTH; i++)
		begin
			rom[i].dest    = {layer_pkg::REPLY_PREFIX, 4'(8 + i)};
			rom[i].payload = 32'hA000_0000 + 32'(i);
		end
	end

	assign int_action = rom[int_sel];

endmodule

// ==== rtl/rf_ctrl.sv ====
`timescale 1ns/1ns

module rf_ctrl
(
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [layer_pkg::RF_DEPTH-1:0] rf_load,
	input  layer_pkg::rf_data_t            rf_wdata,
	output layer_pkg::rf_file_t            rf_file
);

	// One register per load bit
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rf_file <= '0;
		else
		begin
			for (int i = 0; i < layer_pkg::RF_DEPTH; i++)
			begin
				if (rf_load[i])
					rf_file[i] <= rf_wdata;
			end
		end
	end

endmodule

// ==== rtl/mem_ctrl.sv ====
`timescale 1ns/1ns

module mem_ctrl
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 mem_req,
	input  logic                 mem_write,
	input  layer_pkg::mem_addr_t mem_addr,
	input  layer_pkg::word_t     mem_wdata,
	output layer_pkg::word_t     mem_rdata,
	output logic                 mem_ack
);

	layer_pkg::word_t mem [layer_pkg::MEM_DEPTH];
	logic             mem_take;

	// Request is still high while the ack is out, so skip that cycle
	assign mem_take = mem_req && !mem_ack;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mem_ack <= 1'b0;
		else
			mem_ack <= mem_take;
	end

	// Contents kept across sleep
	always_ff @(posedge clk)
	begin
		if (mem_take)
		begin
			if (mem_write)
				mem[mem_addr] <= mem_wdata;
			else
				mem_rdata <= mem[mem_addr];
		end
	end

endmodule

// ==== rtl/lc_power_gate.sv ====
`timescale 1ns/1ns

module lc_power_gate
(
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [layer_pkg::INT_DEPTH:0]  wake,
	input  logic                           sleep_req,
	input  logic                           raw_rx_ack,
	input  logic                           raw_tx_req,
	input  layer_pkg::lc_msg_t             raw_tx_msg,
	input  logic [layer_pkg::RF_DEPTH-1:0] raw_rf_load,
	input  layer_pkg::rf_data_t            raw_rf_wdata,
	input  logic                           raw_mem_req,
	input  logic                           raw_mem_write,
	input  layer_pkg::mem_addr_t           raw_mem_addr,
	input  layer_pkg::word_t               raw_mem_wdata,
	input  layer_pkg::int_vec_t            raw_clr_int,
	input  layer_pkg::int_idx_t            raw_int_sel,
	output logic                           rx_ack,
	output logic                           tx_req,
	output layer_pkg::lc_msg_t             tx_msg,
	output logic [layer_pkg::RF_DEPTH-1:0] rf_load,
	output layer_pkg::rf_data_t            rf_wdata,
	output logic                           mem_req,
	output logic                           mem_write,
	output layer_pkg::mem_addr_t           mem_addr,
	output layer_pkg::word_t               mem_wdata,
	output layer_pkg::int_vec_t            clr_int,
	output layer_pkg::int_idx_t            int_sel,
	output logic                           clk_en,
	output logic                           lc_rst_n,
	output logic                           lc_active
);

	layer_pkg::pwr_state_t pwr_state;
	layer_pkg::pwr_state_t pwr_next;

	// Up and down sequences take one step per cycle
	always_comb
	begin
		pwr_next = pwr_state;
		case (pwr_state)
			layer_pkg::PWR_OFF:
			begin
				// rx_req or any interrupt line
				if (|wake)
					pwr_next = layer_pkg::PWR_UP;
			end
			layer_pkg::PWR_UP:      pwr_next = layer_pkg::PWR_CLK_ON;
			layer_pkg::PWR_CLK_ON:  pwr_next = layer_pkg::PWR_RST_OFF;
			layer_pkg::PWR_RST_OFF: pwr_next = layer_pkg::PWR_ACTIVE;
			layer_pkg::PWR_ACTIVE:
			begin
				if (sleep_req)
					pwr_next = layer_pkg::PWR_ISO_ON;
			end
			layer_pkg::PWR_ISO_ON:  pwr_next = layer_pkg::PWR_RST_ON;
			layer_pkg::PWR_RST_ON:  pwr_next = layer_pkg::PWR_CLK_OFF;
			layer_pkg::PWR_CLK_OFF: pwr_next = layer_pkg::PWR_OFF;
			default:                pwr_next = layer_pkg::PWR_OFF;
		endcase
	end

	// Domain controls come straight from flops
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pwr_state <= layer_pkg::PWR_OFF;
			clk_en    <= 1'b0;
			lc_rst_n  <= 1'b0;
			lc_active <= 1'b0;
		end
		else
		begin
			pwr_state <= pwr_next;
			clk_en    <= pwr_next inside {layer_pkg::PWR_CLK_ON, layer_pkg::PWR_RST_OFF,
				layer_pkg::PWR_ACTIVE, layer_pkg::PWR_ISO_ON, layer_pkg::PWR_RST_ON};
			lc_rst_n  <= pwr_next inside {layer_pkg::PWR_RST_OFF, layer_pkg::PWR_ACTIVE,
				layer_pkg::PWR_ISO_ON};
			lc_active <= (pwr_next == layer_pkg::PWR_ACTIVE);
		end
	end

	// Isolation clamps everything to zero
	assign rx_ack    = lc_active ? raw_rx_ack    : 1'b0;
	assign tx_req    = lc_active ? raw_tx_req    : 1'b0;
	assign tx_msg    = lc_active ? raw_tx_msg    : '0;
	assign rf_load   = lc_active ? raw_rf_load   : '0;
	assign rf_wdata  = lc_active ? raw_rf_wdata  : '0;
	assign mem_req   = lc_active ? raw_mem_req   : 1'b0;
	assign mem_write = lc_active ? raw_mem_write : 1'b0;
	assign mem_addr  = lc_active ? raw_mem_addr  : '0;
	assign mem_wdata = lc_active ? raw_mem_wdata : '0;
	assign clr_int   = lc_active ? raw_clr_int   : '0;
	assign int_sel   = lc_active ? raw_int_sel   : '0;

endmodule

// ==== rtl/layer_ctrl.sv ====
`timescale 1ns/1ns

module layer_ctrl
(
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           clk_en,
	input  layer_pkg::lc_msg_t             rx_msg,
	input  logic                           rx_req,
	input  logic                           rx_pend,
	input  logic                           tx_ack,
	input  layer_pkg::int_vec_t            int_vector,
	input  layer_pkg::rf_file_t            rf_file,
	input  logic                           mem_ack,
	input  layer_pkg::word_t               mem_rdata,
	input  layer_pkg::int_action_t         int_action,
	output logic                           rx_ack,
	output logic                           sleep_req,
	output layer_pkg::lc_msg_t             tx_msg,
	output logic                           tx_req,
	output logic [layer_pkg::RF_DEPTH-1:0] rf_load,
	output layer_pkg::rf_data_t            rf_wdata,
	output logic                           mem_req,
	output logic                           mem_write,
	output layer_pkg::mem_addr_t           mem_addr,
	output layer_pkg::word_t               mem_wdata,
	output layer_pkg::int_vec_t            clr_int,
	output layer_pkg::int_idx_t            int_sel
);

	layer_pkg::lc_state_t state;
	logic                 rx_ours;
	logic [3:0]           rx_fu;
	layer_pkg::rf_idx_t   rf_idx;
	logic                 rx_new;

	// Lowest pending line has priority
	function automatic layer_pkg::int_idx_t lowest_set(input layer_pkg::int_vec_t vec);
		layer_pkg::int_idx_t idx;
		idx = '0;
		for (int i = layer_pkg::INT_DEPTH - 1; i >= 0; i--)
		begin
			if (vec[i])
				idx = layer_pkg::int_idx_t'(i);
		end
		return idx;
	endfunction

	assign rx_ours = (rx_msg.addr[7:4] == layer_pkg::LAYER_PREFIX);
	assign rx_fu   = rx_msg.addr[3:0];
	assign rf_idx  = rx_msg.data[27:24];
	// Request from the last ack is still high for one more cycle
	assign rx_new  = rx_req && !rx_ack;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= layer_pkg::LC_IDLE;
			rx_ack    <= 1'b0;
			sleep_req <= 1'b0;
			tx_req    <= 1'b0;
			rf_load   <= '0;
			mem_req   <= 1'b0;
			mem_write <= 1'b0;
			clr_int   <= '0;
		end
		else if (clk_en)
		begin
			rx_ack  <= 1'b0;
			rf_load <= '0;
			clr_int <= '0;
			case (state)
				layer_pkg::LC_IDLE:
				begin
					if (!rx_ack && (|int_vector))
						state <= layer_pkg::LC_INT_LOAD;
					else if (rx_new)
					begin
						// Foreign prefix is acked and dropped
						rx_ack <= 1'b1;
						if (rx_ours)
						begin
							case (rx_fu)
								layer_pkg::FU_SLEEP:
								begin
									sleep_req <= 1'b1;
									state     <= layer_pkg::LC_SLEEP;
								end
								layer_pkg::FU_RF_WRITE:
									rf_load[rf_idx] <= 1'b1;
								layer_pkg::FU_RF_READ:
								begin
									tx_req <= 1'b1;
									state  <= layer_pkg::LC_REPLY;
								end
								layer_pkg::FU_MEM_WRITE:
								begin
									if (rx_pend)
										state <= layer_pkg::LC_MEM_DATA;
								end
								layer_pkg::FU_MEM_READ:
								begin
									mem_req   <= 1'b1;
									mem_write <= 1'b0;
									state     <= layer_pkg::LC_MEM_WAIT;
								end
								default:
									state <= layer_pkg::LC_IDLE;
							endcase
						end
					end
				end
				// Second word of a memory write
				layer_pkg::LC_MEM_DATA:
				begin
					if (rx_new)
					begin
						mem_req   <= 1'b1;
						mem_write <= 1'b1;
						state     <= layer_pkg::LC_MEM_WAIT;
					end
				end
				layer_pkg::LC_MEM_WAIT:
				begin
					if (mem_ack)
					begin
						mem_req <= 1'b0;
						if (mem_write)
						begin
							rx_ack <= 1'b1;
							state  <= layer_pkg::LC_IDLE;
						end
						else
						begin
							tx_req <= 1'b1;
							state  <= layer_pkg::LC_REPLY;
						end
					end
				end
				layer_pkg::LC_REPLY:
				begin
					if (tx_ack)
					begin
						tx_req <= 1'b0;
						state  <= layer_pkg::LC_IDLE;
					end
				end
				layer_pkg::LC_INT_LOAD:
				begin
					tx_req <= 1'b1;
					state  <= layer_pkg::LC_INT_TX;
				end
				layer_pkg::LC_INT_TX:
				begin
					if (tx_ack)
					begin
						tx_req           <= 1'b0;
						clr_int[int_sel] <= 1'b1;
						state            <= layer_pkg::LC_INT_CLR;
					end
				end
				// Gives the environment a cycle to drop the line
				layer_pkg::LC_INT_CLR:
					state <= layer_pkg::LC_IDLE;
				// Held here until the domain reset arrives
				layer_pkg::LC_SLEEP:
					sleep_req <= 1'b1;
				default:
					state <= layer_pkg::LC_IDLE;
			endcase
		end
	end

	// Message payload, qualified by the control flops above
	always_ff @(posedge clk)
	begin
		if (clk_en)
		begin
			case (state)
				layer_pkg::LC_IDLE:
				begin
					int_sel     <= lowest_set(int_vector);
					rf_wdata    <= rx_msg.data[23:0];
					mem_addr    <= rx_msg.data[5:0];
					tx_msg.addr <= {layer_pkg::REPLY_PREFIX, rx_fu};
					tx_msg.data <= {4'h0, rf_idx, rf_file[rf_idx]};
				end
				layer_pkg::LC_MEM_DATA:
					mem_wdata <= rx_msg.data;
				layer_pkg::LC_MEM_WAIT:
				begin
					if (mem_ack)
						tx_msg.data <= mem_rdata;
				end
				layer_pkg::LC_INT_LOAD:
				begin
					tx_msg.addr <= int_action.dest;
					tx_msg.data <= int_action.payload;
				end
				default:
					int_sel <= int_sel;
			endcase
		end
	end

endmodule

// ==== rtl/layer_wrapper.sv ====
`timescale 1ns/1ns

module layer_wrapper
(
	input  logic                clk,
	input  logic                rst_n,
	input  layer_pkg::lc_msg_t  rx_msg,
	input  logic                rx_req,
	input  logic                rx_pend,
	input  logic                tx_ack,
	input  layer_pkg::int_vec_t int_vector,
	output logic                rx_ack,
	output layer_pkg::lc_msg_t  tx_msg,
	output logic                tx_req,
	output layer_pkg::int_vec_t clr_int,
	output logic                lc_active
);

	// Raw outputs of the switchable domain
	logic                           lc_rx_ack;
	logic                           lc_tx_req;
	layer_pkg::lc_msg_t             lc_tx_msg;
	logic [layer_pkg::RF_DEPTH-1:0] lc_rf_load;
	layer_pkg::rf_data_t            lc_rf_wdata;
	logic                           lc_mem_req;
	logic                           lc_mem_write;
	layer_pkg::mem_addr_t           lc_mem_addr;
	layer_pkg::word_t               lc_mem_wdata;
	layer_pkg::int_vec_t            lc_clr_int;
	layer_pkg::int_idx_t            lc_int_sel;
	logic                           sleep_req;

	// Power control toward the controller
	logic                           clk_en;
	logic                           lc_rst_n;

	// Isolated side, always on
	logic [layer_pkg::RF_DEPTH-1:0] rf_load;
	layer_pkg::rf_data_t            rf_wdata;
	logic                           mem_req;
	logic                           mem_write;
	layer_pkg::mem_addr_t           mem_addr;
	layer_pkg::word_t               mem_wdata;
	layer_pkg::int_idx_t            int_sel;

	// Always-on results back to the controller
	layer_pkg::word_t               mem_rdata;
	logic                           mem_ack;
	layer_pkg::rf_file_t            rf_file;
	layer_pkg::int_action_t         int_action;

	layer_ctrl lc0 (
		.clk        (clk),
		.rst_n      (lc_rst_n),
		.clk_en     (clk_en),
		.rx_msg     (rx_msg),
		.rx_req     (rx_req),
		.rx_pend    (rx_pend),
		.tx_ack     (tx_ack),
		.int_vector (int_vector),
		.rf_file    (rf_file),
		.mem_ack    (mem_ack),
		.mem_rdata  (mem_rdata),
		.int_action (int_action),
		.rx_ack     (lc_rx_ack),
		.sleep_req  (sleep_req),
		.tx_msg     (lc_tx_msg),
		.tx_req     (lc_tx_req),
		.rf_load    (lc_rf_load),
		.rf_wdata   (lc_rf_wdata),
		.mem_req    (lc_mem_req),
		.mem_write  (lc_mem_write),
		.mem_addr   (lc_mem_addr),
		.mem_wdata  (lc_mem_wdata),
		.clr_int    (lc_clr_int),
		.int_sel    (lc_int_sel)
	);

	lc_power_gate pg0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.wake          ({rx_req, int_vector}),
		.sleep_req     (sleep_req),
		.raw_rx_ack    (lc_rx_ack),
		.raw_tx_req    (lc_tx_req),
		.raw_tx_msg    (lc_tx_msg),
		.raw_rf_load   (lc_rf_load),
		.raw_rf_wdata  (lc_rf_wdata),
		.raw_mem_req   (lc_mem_req),
		.raw_mem_write (lc_mem_write),
		.raw_mem_addr  (lc_mem_addr),
		.raw_mem_wdata (lc_mem_wdata),
		.raw_clr_int   (lc_clr_int),
		.raw_int_sel   (lc_int_sel),
		.rx_ack        (rx_ack),
		.tx_req        (tx_req),
		.tx_msg        (tx_msg),
		.rf_load       (rf_load),
		.rf_wdata      (rf_wdata),
		.mem_req       (mem_req),
		.mem_write     (mem_write),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.clr_int       (clr_int),
		.int_sel       (int_sel),
		.clk_en        (clk_en),
		.lc_rst_n      (lc_rst_n),
		.lc_active     (lc_active)
	);

	mem_ctrl mem0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_req   (mem_req),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_ack   (mem_ack)
	);

	rf_ctrl rf0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.rf_load  (rf_load),
		.rf_wdata (rf_wdata),
		.rf_file  (rf_file)
	);

	int_action_rom ir0 (
		.int_sel    (int_sel),
		.int_action (int_action)
	);

endmodule

// ==== test/layer_wrapper_properties.sv ====
`timescale 1ns/1ns

module layer_wrapper_properties
(
	input logic                clk,
	input logic                rst_n,
	input logic                rx_ack,
	input logic                tx_req,
	input logic                tx_ack,
	input logic                lc_active,
	input logic                clk_en,
	input logic                lc_rst_n,
	input layer_pkg::lc_msg_t  tx_msg,
	input layer_pkg::int_vec_t clr_int
);

	// Outgoing message held until the environment takes it
	tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
		tx_req && !tx_ack |=> tx_req)
		else $error("tx_req dropped before tx_ack");

	tx_msg_stable: assert property (@(posedge clk) disable iff (!rst_n)
		tx_req && !tx_ack |=> $stable(tx_msg))
		else $error("tx_msg changed while tx_req waited for tx_ack");

	rx_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		rx_ack |=> !rx_ack)
		else $error("rx_ack longer than one cycle");

	clr_int_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		(|clr_int) |=> (clr_int == '0))
		else $error("clr_int longer than one cycle");

	// Isolation covers every cycle with the domain clock stopped or in reset
	isolation: assert property (@(posedge clk) disable iff (!rst_n)
		(!clk_en || !lc_rst_n) |->
			(!lc_active && !rx_ack && !tx_req && (clr_int == '0)))
		else $error("Control output active while the domain is stopped or in reset");

endmodule

bind layer_wrapper layer_wrapper_properties props0 (
	.clk       (clk),
	.rst_n     (rst_n),
	.rx_ack    (rx_ack),
	.tx_req    (tx_req),
	.tx_ack    (tx_ack),
	.lc_active (lc_active),
	.clk_en    (clk_en),
	.lc_rst_n  (lc_rst_n),
	.tx_msg    (tx_msg),
	.clr_int   (clr_int)
);

// ==== test/layer_wrapper_tb.sv ====
`timescale 1ns/1ns

module layer_wrapper_tb;

	logic                clk;
	logic                rst_n;
	layer_pkg::lc_msg_t  rx_msg;
	logic                rx_req;
	logic                rx_pend;
	logic                tx_ack;
	layer_pkg::int_vec_t int_vector;
	logic                rx_ack;
	layer_pkg::lc_msg_t  tx_msg;
	logic                tx_req;
	layer_pkg::int_vec_t clr_int;
	logic                lc_active;

	int          value_errors;
	int          other_errors;
	logic [31:0] lfsr_state;

	layer_wrapper dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_msg     (rx_msg),
		.rx_req     (rx_req),
		.rx_pend    (rx_pend),
		.tx_ack     (tx_ack),
		.int_vector (int_vector),
		.rx_ack     (rx_ack),
		.tx_msg     (tx_msg),
		.tx_req     (tx_req),
		.clr_int    (clr_int),
		.lc_active  (lc_active)
	);

	always #2 clk = ~clk;

	// Galois form, one output bit per step
	function automatic logic lfsr_step();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		return out;
	endfunction

	// 0 rx_ack, 1 tx_req, else any clr_int
	function automatic logic observe(input int which);
		case (which)
			0:       return rx_ack;
			1:       return tx_req;
			default: return |clr_int;
		endcase
	endfunction

	task automatic wait_until(input int which, input string what, output logic seen);
		int n;
		n = 0;
		while (!observe(which) && n < 60)
		begin
			@(negedge clk);
			n++;
		end
		seen = observe(which);
		if (!seen)
		begin
			$display("Timeout: %s did not happen within 60 cycles", what);
			other_errors++;
		end
	endtask

	task automatic send_msg(input string name, input layer_pkg::addr_t addr,
		input layer_pkg::word_t data, input logic pend, input logic chk_wake);
		int   n;
		logic seen;
		@(posedge clk);
		#1;
		if (chk_wake && lc_active)
		begin
			$display("%s: domain was already on before the wake message", name);
			other_errors++;
		end
		rx_msg.addr = addr;
		rx_msg.data = data;
		rx_pend     = pend;
		rx_req      = 1'b1;
		if (chk_wake)
		begin
			// Edges from the first sampled rx_req until lc_active is seen
			n    = 0;
			seen = 1'b0;
			while (!seen && n < 60)
			begin
				@(posedge clk);
				n++;
				@(negedge clk);
				seen = lc_active;
			end
			if (!seen)
			begin
				$display("Timeout: %s domain never woke up", name);
				other_errors++;
			end
			else if (n != 4)
			begin
				$display("ERR %s wake cycles expected 4 actual %0d", name, n);
				value_errors++;
			end
		end
		wait_until(0, "rx_ack", seen);
		@(posedge clk);
		#1;
		rx_req  = 1'b0;
		rx_pend = 1'b0;
	endtask

	task automatic ack_tx();
		logic [1:0] delay;
		delay[1] = lfsr_step();
		delay[0] = lfsr_step();
		repeat (delay) @(posedge clk);
		@(posedge clk);
		#1 tx_ack = 1'b1;
		@(posedge clk);
		#1 tx_ack = 1'b0;
	endtask

	task automatic expect_reply(input string name, input layer_pkg::addr_t exp_addr,
		input layer_pkg::word_t exp_data);
		logic seen;
		wait_until(1, "tx_req for a reply", seen);
		if (seen)
		begin
			if (tx_msg.addr !== exp_addr)
			begin
				$display("ERR %s addr expected %h actual %h", name, exp_addr, tx_msg.addr);
				value_errors++;
			end
			if (tx_msg.data !== exp_data)
			begin
				$display("ERR %s data expected %h actual %h", name, exp_data, tx_msg.data);
				value_errors++;
			end
			ack_tx();
		end
	endtask

	// No reply may follow a write, a dropped message or a first word
	task automatic expect_silence(input string name);
		repeat (3)
		begin
			@(negedge clk);
			if (tx_req !== 1'b0)
			begin
				$display("ERR %s tx_req expected 0 actual %b", name, tx_req);
				value_errors++;
			end
		end
	endtask

	task automatic serve_ints(input string name, input layer_pkg::int_vec_t vec, input int count);
		layer_pkg::int_vec_t pend;
		layer_pkg::int_vec_t exp_clr;
		layer_pkg::lc_msg_t  exp_msg;
		int                  idx;
		int                  served;
		logic                seen;
		logic                extra;
		@(posedge clk);
		#1 int_vector = vec;
		pend   = vec;
		served = 0;
		seen   = 1'b1;
		while (pend != '0 && seen)
		begin
			// Lowest pending line goes first
			idx = 0;
			for (int i = layer_pkg::INT_DEPTH - 1; i >= 0; i--)
			begin
				if (pend[i])
					idx = i;
			end
			exp_msg.addr = {layer_pkg::REPLY_PREFIX, 4'(8 + idx)};
			exp_msg.data = 32'hA000_0000 + 32'(idx);
			exp_clr      = layer_pkg::int_vec_t'(1 << idx);
			wait_until(1, "tx_req for an interrupt message", seen);
			if (seen)
			begin
				if (tx_msg !== exp_msg)
				begin
					$display("ERR %s line %0d expected %h actual %h", name, idx, exp_msg, tx_msg);
					value_errors++;
				end
				ack_tx();
				wait_until(2, "clr_int pulse", seen);
				if (seen && clr_int !== exp_clr)
				begin
					$display("ERR %s clr_int expected %b actual %b", name, exp_clr, clr_int);
					value_errors++;
				end
				@(posedge clk);
				#1 pend = pend & ~exp_clr;
				int_vector = pend;
				served++;
			end
		end
		// A message after the last cleared line would be one too many
		extra = 1'b0;
		repeat (4)
		begin
			@(negedge clk);
			if (tx_req === 1'b1)
				extra = 1'b1;
		end
		if (extra)
			served++;
		if (served != count)
		begin
			$display("ERR %s messages expected %0d actual %0d", name, count, served);
			value_errors++;
		end
	endtask

	task automatic run_op(input int step, input logic [31:0] op, input logic [31:0] addr,
		input logic [31:0] data, input logic [31:0] pend, input logic [31:0] exp);
		string            name;
		layer_pkg::addr_t reply_addr;
		name       = $sformatf("step%0d_op%0d", step, op);
		reply_addr = {layer_pkg::REPLY_PREFIX, addr[3:0]};
		case (op)
			1:
			begin
				send_msg(name, addr[7:0], data, pend[0], exp[0]);
				expect_silence(name);
			end
			2:
			begin
				send_msg(name, addr[7:0], data, pend[0], 1'b0);
				expect_reply(name, reply_addr, exp);
			end
			4:
				serve_ints(name, data[3:0], exp);
			5:
			begin
				send_msg(name, addr[7:0], data, pend[0], 1'b0);
				// Isolation is applied in the cycle right after the ack
				if (lc_active !== exp[0])
				begin
					$display("ERR %s lc_active expected %b actual %b", name, exp[0], lc_active);
					value_errors++;
				end
			end
			default:
			begin
				$display("%s: unknown operation code in the stimulus file", name);
				other_errors++;
			end
		endcase
	endtask

	initial
	begin
		int          fd;
		int          got;
		int          step;
		logic [31:0] f_op;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		logic [31:0] f_pend;
		logic [31:0] f_exp;
		clk          = 1'b0;
		rst_n        = 1'b0;
		rx_msg       = '0;
		rx_req       = 1'b0;
		rx_pend      = 1'b0;
		tx_ack       = 1'b0;
		int_vector   = '0;
		value_errors = 0;
		other_errors = 0;
		lfsr_state   = 32'h33ebd7f1;
		step         = 0;
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;
		@(negedge clk);
		if ({rx_ack, tx_req, clr_int, lc_active} !== 7'd0)
		begin
			$display("ERR reset_outputs expected %h actual %h", 7'd0,
				{rx_ack, tx_req, clr_int, lc_active});
			value_errors++;
		end
		fd = $fopen("test/layer_wrapper_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file");
			other_errors++;
		end
		else
		begin
			got = $fscanf(fd, "%h %h %h %h %h\n", f_op, f_addr, f_data, f_pend, f_exp);
			while (got == 5)
			begin
				step++;
				run_op(step, f_op, f_addr, f_data, f_pend, f_exp);
				got = $fscanf(fd, "%h %h %h %h %h\n", f_op, f_addr, f_data, f_pend, f_exp);
			end
			$fclose(fd);
		end
		$display("Summary: %0d operations, %0d value errors, %0d other errors",
			step, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== layer_wrapper.f ====
rtl/layer_pkg.sv
rtl/int_action_rom.sv
rtl/rf_ctrl.sv
rtl/mem_ctrl.sv
rtl/lc_power_gate.sv
rtl/layer_ctrl.sv
rtl/layer_wrapper.sv
test/layer_wrapper_properties.sv
test/layer_wrapper_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f layer_wrapper.f --top-module layer_wrapper_tb \
	&& ./obj_dir/Vlayer_wrapper_tb | tee /dev/stderr | grep -q '^No errors$' \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// ==== test/layer_wrapper_stimulus.txt ====
1 52 03123456 0 1
1 52 0A00ABCD 0 0
2 53 03000000 0 03123456
2 53 0A000000 0 0A00ABCD
2 53 07000000 0 07000000
1 52 0FFFFFFF 0 0
2 53 0F000000 0 0FFFFFFF
1 52 00000001 0 0
2 53 00000000 0 00000001
1 54 00000011 1 0
1 54 DEADBEEF 0 0
2 55 00000011 0 DEADBEEF
1 54 0000003E 1 0
1 54 12345678 0 0
2 55 0000003E 0 12345678
2 55 00000011 0 DEADBEEF
1 54 00000000 1 0
1 54 CAFEF00D 0 0
2 55 00000000 0 CAFEF00D
4 00 0000000B 0 3
4 00 00000004 0 1
4 00 0000000F 0 4
5 50 00000000 0 0
2 53 03000000 0 03123456
2 55 0000003E 0 12345678
2 53 0F000000 0 0FFFFFFF
1 72 03999999 0 0
2 53 03000000 0 03123456
1 A2 0A111111 0 0
2 53 0A000000 0 0A00ABCD
1 A3 03000000 0 0
5 50 00000000 0 0
4 00 00000006 0 2
2 55 00000011 0 DEADBEEF
2 53 00000000 0 00000001
